/* design/opc_macros.svh */
`ifndef OPC_MACROS_SVH
`define OPC_MACROS_SVH

// page zero stays free for program data.
`define OPC_RESET_PC 11'h100

`define OPC_MEM_DEPTH 2048

`define OPC_AXI_AW 14

// register block above the memory window.
`define OPC_CTRL_OFS   14'h2000
`define OPC_STATUS_OFS 14'h2004
`define OPC_REGS_OFS   14'h2008

`endif

/* design/opc_pkg.sv */
package opc_pkg;

   typedef logic [10:0] addr_t;
   typedef logic [7:0]  data_t;
   typedef logic [4:0]  opcode_t;
   // bit 0 is the carry.
   typedef logic [2:0]  link_t;
   typedef logic [1:0]  axi_resp_t;

   typedef enum logic [2:0] {
      fetch0 = 3'd0,
      fetch1 = 3'd1,
      rdmem  = 3'd2,
      rdmem2 = 3'd3,
      exec   = 3'd4
   } cpu_state_t;

   localparam axi_resp_t okay   = 2'b00;
   localparam axi_resp_t slverr = 2'b10;

   // alu group, opcode bit 4 free.
   localparam logic [3:0] alu_and = 4'b0000;
   localparam logic [3:0] alu_lda = 4'b0001;
   localparam logic [3:0] alu_not = 4'b0010;
   localparam logic [3:0] alu_add = 4'b0011;

   localparam opcode_t op_ldap = 5'b01001;
   localparam opcode_t op_sta  = 5'b11000;
   localparam opcode_t op_stap = 5'b01000;
   localparam opcode_t op_jpc  = 5'b11001;
   localparam opcode_t op_jpz  = 5'b11010;
   localparam opcode_t op_jp   = 5'b11011;
   localparam opcode_t op_jsr  = 5'b11100;
   localparam opcode_t op_rts  = 5'b11101;
   localparam opcode_t op_lxa  = 5'b11110;

endpackage

/* design/opc_bus_if.sv */
`timescale 1ns/1ps

interface opc_bus_if
   import opc_pkg::*;
();

   addr_t address;
   data_t wdata;
   data_t rdata;
   // low for a store cycle.
   logic  rnw;

   modport core (
      output address,
      output wdata,
      output rnw,
      input  rdata
   );

   modport mem (
      input  address,
      input  wdata,
      input  rnw,
      output rdata
   );

endinterface

/* design/opc_core.sv */
`timescale 1ns/1ps
`include "opc_macros.svh"

module opc_core
   import opc_pkg::*;
(
   input  logic    clk,
   input  logic    reset_b,
   input  logic    run,
   opc_bus_if.core bus,
   output logic    halted,
   output addr_t   pc,
   output data_t   acc,
   output link_t   link
);

   cpu_state_t state;
   opcode_t    ir;
   addr_t      opr;
   addr_t      inst_addr;
   logic       halt_q;
   logic       step;
   logic       writeback;

   assign step   = run & ~halt_q;
   assign halted = halt_q & run;

   // sta and stap store acc in exec.
   assign writeback   = run && (state == exec) && (ir == op_sta || ir == op_stap);
   assign bus.rnw     = ~writeback;
   assign bus.wdata   = acc;
   assign bus.address = (writeback || state == rdmem || state == rdmem2) ? opr : pc;

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         state <= fetch0;
      else if (!step)
         state <= fetch0;
      else
      begin
         case (state)
            fetch0:  state <= fetch1;
            fetch1:  state <= ir[4] ? exec : rdmem;
            rdmem:   state <= (ir == op_ldap) ? rdmem2 : exec;
            rdmem2:  state <= exec;
            default: state <= fetch0;
         endcase
      end
   end

   // instruction and operand capture.
   always_ff @(posedge clk)
   begin
      if (step)
      begin
         case (state)
            fetch0:
            begin
               ir        <= bus.rdata[7:3];
               opr[10:8] <= bus.rdata[2:0];
               inst_addr <= pc;
            end
            fetch1, rdmem: opr[7:0] <= bus.rdata;
            // pointer target lands in page zero.
            rdmem2:  opr <= {3'b000, bus.rdata};
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         pc     <= `OPC_RESET_PC;
         acc    <= '0;
         link   <= '0;
         halt_q <= 1'b0;
      end
      else if (!run)
      begin
         pc     <= `OPC_RESET_PC;
         halt_q <= 1'b0;
      end
      else if (!halt_q)
      begin
         if (state == fetch0 || state == fetch1)
            pc <= pc + 11'd1;
         else if (state == exec)
         begin
            case (ir)
               op_jp:   pc <= opr;
               op_jpc:  pc <= link[0] ? opr : pc;
               op_jpz:  pc <= (acc == '0) ? opr : pc;
               op_jsr:  pc <= opr;
               op_rts:  pc <= {link, acc};
               default: ;
            endcase
            case (ir)
               op_jsr:  {link, acc} <= pc;
               op_lxa:  {link, acc} <= {acc[2:0], 5'b00000, link};
               op_ldap: acc <= opr[7:0];
               default:
               begin
                  case (ir[3:0])
                     alu_and: {link[0], acc} <= {1'b0, acc & opr[7:0]};
                     alu_lda: acc <= opr[7:0];
                     alu_not: acc <= ~opr[7:0];
                     alu_add: {link[0], acc} <= {1'b0, acc} + {8'd0, link[0]} + {1'b0, opr[7:0]};
                     default: ;
                  endcase
               end
            endcase
            // a jump onto itself ends the program.
            if (ir == op_jp && opr == inst_addr)
               halt_q <= 1'b1;
         end
      end
   end

endmodule

/* design/opc_ram.sv */
`timescale 1ns/1ps
`include "opc_macros.svh"

module opc_ram
   import opc_pkg::*;
(
   input  logic   clk,
   opc_bus_if.mem bus,
   input  addr_t  host_addr,
   input  data_t  host_wdata,
   input  logic   host_we,
   output data_t  host_rdata
);

   data_t mem [`OPC_MEM_DEPTH];

   // both ports read without a clock.
   assign bus.rdata  = mem[bus.address];
   assign host_rdata = mem[host_addr];

   // host writes only while the core is stopped.
   always_ff @(posedge clk)
   begin
      if (host_we)
         mem[host_addr] <= host_wdata;
      if (!bus.rnw)
         mem[bus.address] <= bus.wdata;
   end

endmodule

/* design/opc_axil_host.sv */
`timescale 1ns/1ps
`include "opc_macros.svh"

module opc_axil_host
   import opc_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset_b,
   input  logic [`OPC_AXI_AW-1:0] awaddr,
   input  logic                   awvalid,
   output logic                   awready,
   input  logic [31:0]            wdata,
   input  logic [3:0]             wstrb,
   input  logic                   wvalid,
   output logic                   wready,
   output axi_resp_t              bresp,
   output logic                   bvalid,
   input  logic                   bready,
   input  logic [`OPC_AXI_AW-1:0] araddr,
   input  logic                   arvalid,
   output logic                   arready,
   output logic [31:0]            rdata,
   output axi_resp_t              rresp,
   output logic                   rvalid,
   input  logic                   rready,
   output logic                   run,
   input  logic                   halted,
   input  addr_t                  pc,
   input  data_t                  acc,
   input  link_t                  link,
   output addr_t                  host_addr,
   output data_t                  host_wdata,
   output logic                   host_we,
   input  data_t                  host_rdata
);

   logic        wr_fire;
   logic        rd_fire;
   logic        aw_mem;
   logic        aw_ctrl;
   logic        aw_ok;
   logic        ar_mem;
   logic        ar_ctrl;
   logic        ar_status;
   logic        ar_regs;
   logic        ar_ok;
   logic [31:0] rd_word;

   assign aw_mem  = ~awaddr[`OPC_AXI_AW-1];
   assign aw_ctrl = (awaddr == `OPC_CTRL_OFS);
   // status and regs accept writes and ignore them.
   assign aw_ok = aw_mem ? ~run
                         : (aw_ctrl || awaddr == `OPC_STATUS_OFS || awaddr == `OPC_REGS_OFS);

   assign ar_mem    = ~araddr[`OPC_AXI_AW-1];
   assign ar_ctrl   = (araddr == `OPC_CTRL_OFS);
   assign ar_status = (araddr == `OPC_STATUS_OFS);
   assign ar_regs   = (araddr == `OPC_REGS_OFS);
   assign ar_ok     = ar_mem ? ~run : (ar_ctrl || ar_status || ar_regs);

   assign wr_fire = awready & awvalid & wvalid;
   // one host address port, so reads wait out a write handshake.
   assign arready = ~rvalid & ~awready;
   assign rd_fire = arvalid & arready;

   assign host_addr  = wr_fire ? awaddr[`OPC_AXI_AW-2:2] : araddr[`OPC_AXI_AW-2:2];
   assign host_wdata = wdata[7:0];
   assign host_we    = wr_fire & aw_mem & ~run & wstrb[0];

   always_comb
   begin
      rd_word = '0;
      if (ar_mem)
         rd_word = {24'd0, host_rdata};
      else if (ar_ctrl)
         rd_word = {31'd0, run};
      else if (ar_status)
         rd_word = {31'd0, halted};
      else if (ar_regs)
         rd_word = {5'd0, pc, 5'd0, link, acc};
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
         rvalid  <= 1'b0;
         run     <= 1'b0;
      end
      else
      begin
         // single cycle ready pulse per write.
         awready <= awvalid & wvalid & ~awready & ~bvalid;
         wready  <= awvalid & wvalid & ~awready & ~bvalid;
         if (bvalid && bready)
            bvalid <= 1'b0;
         else if (wr_fire)
            bvalid <= 1'b1;
         if (rvalid && rready)
            rvalid <= 1'b0;
         else if (rd_fire)
            rvalid <= 1'b1;
         if (wr_fire && aw_ctrl && wstrb[0])
            run <= wdata[0];
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_fire)
         bresp <= aw_ok ? okay : slverr;
      if (rd_fire)
      begin
         rdata <= ar_ok ? rd_word : 32'd0;
         rresp <= ar_ok ? okay : slverr;
      end
   end

endmodule

/* design/opc_top.sv */
`timescale 1ns/1ps
`include "opc_macros.svh"

module opc_top
   import opc_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset_b,
   input  logic [`OPC_AXI_AW-1:0] awaddr,
   input  logic                   awvalid,
   output logic                   awready,
   input  logic [31:0]            wdata,
   input  logic [3:0]             wstrb,
   input  logic                   wvalid,
   output logic                   wready,
   output axi_resp_t              bresp,
   output logic                   bvalid,
   input  logic                   bready,
   input  logic [`OPC_AXI_AW-1:0] araddr,
   input  logic                   arvalid,
   output logic                   arready,
   output logic [31:0]            rdata,
   output axi_resp_t              rresp,
   output logic                   rvalid,
   input  logic                   rready
);

   logic  run;
   logic  halted;
   addr_t pc;
   data_t acc;
   link_t link;
   addr_t host_addr;
   data_t host_wdata;
   logic  host_we;
   data_t host_rdata;

   opc_bus_if cpu_bus ();

   opc_axil_host u_host (
      .clk        (clk),
      .reset_b    (reset_b),
      .awaddr     (awaddr),
      .awvalid    (awvalid),
      .awready    (awready),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .wvalid     (wvalid),
      .wready     (wready),
      .bresp      (bresp),
      .bvalid     (bvalid),
      .bready     (bready),
      .araddr     (araddr),
      .arvalid    (arvalid),
      .arready    (arready),
      .rdata      (rdata),
      .rresp      (rresp),
      .rvalid     (rvalid),
      .rready     (rready),
      .run        (run),
      .halted     (halted),
      .pc         (pc),
      .acc        (acc),
      .link       (link),
      .host_addr  (host_addr),
      .host_wdata (host_wdata),
      .host_we    (host_we),
      .host_rdata (host_rdata)
   );

   opc_core u_core (
      .clk     (clk),
      .reset_b (reset_b),
      .run     (run),
      .bus     (cpu_bus.core),
      .halted  (halted),
      .pc      (pc),
      .acc     (acc),
      .link    (link)
   );

   opc_ram u_ram (
      .clk        (clk),
      .bus        (cpu_bus.mem),
      .host_addr  (host_addr),
      .host_wdata (host_wdata),
      .host_we    (host_we),
      .host_rdata (host_rdata)
   );

endmodule

/* verif/opc_checker.sv */
`timescale 1ns/1ps

module opc_checker
   import opc_pkg::*;
(
   input logic        clk,
   input logic        awready,
   input logic        wready,
   input logic        bvalid,
   input logic        bready,
   input axi_resp_t   bresp,
   input logic        rvalid,
   input logic        rready,
   input logic [31:0] rdata,
   input axi_resp_t   rresp
);

   logic [31:0] exp_rdata [$];
   axi_resp_t   exp_rresp [$];
   bit          exp_care [$];
   axi_resp_t   exp_bresp [$];
   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   int          test_start = 0;

   task automatic expect_read(input logic [31:0] d, input axi_resp_t r, input bit care);
      exp_rdata.push_back(d);
      exp_rresp.push_back(r);
      exp_care.push_back(care);
   endtask

   task automatic expect_write(input axi_resp_t r);
      exp_bresp.push_back(r);
   endtask

   task automatic note_failure(input string msg);
      $display("%s", msg);
      errors++;
   endtask

   task automatic test_done(input string name);
      $display("test %s: %s", name, (errors == test_start) ? "pass" : "fail");
      tests++;
      test_start = errors;
   endtask

   task automatic summary();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
   endtask

   // responses are taken at the handshake edge.
   always @(posedge clk)
   begin
      if (awready != wready)
         note_failure("awready and wready did not pulse together");
      if (rvalid && rready)
      begin
         if (exp_rresp.size() == 0)
            note_failure("read response arrived with no read outstanding");
         else
         begin
            checks++;
            if (rresp != exp_rresp[0])
               note_failure($sformatf("error rresp expected %h got %h", exp_rresp[0], rresp));
            if (exp_care[0] && rdata != exp_rdata[0])
               note_failure($sformatf("error rdata expected %h got %h", exp_rdata[0], rdata));
            void'(exp_rdata.pop_front());
            void'(exp_rresp.pop_front());
            void'(exp_care.pop_front());
         end
      end
      if (bvalid && bready)
      begin
         if (exp_bresp.size() == 0)
            note_failure("write response arrived with no write outstanding");
         else
         begin
            checks++;
            if (bresp != exp_bresp[0])
               note_failure($sformatf("error bresp expected %h got %h", exp_bresp[0], bresp));
            void'(exp_bresp.pop_front());
         end
      end
   end

endmodule

/* verif/opc_assert.sv */
`timescale 1ns/1ps

module opc_assert (
   input logic clk,
   input logic reset_b,
   input logic bvalid,
   input logic bready,
   input logic run,
   input logic halted,
   input logic core_rnw
);

   bvalid_held: assert property (@(posedge clk) disable iff (!reset_b)
      bvalid && !bready |=> bvalid)
      else $error("bvalid dropped before bready");

   // core stores only while running and not halted.
   no_store_when_stopped: assert property (@(posedge clk) disable iff (!reset_b)
      (!run || halted) |-> core_rnw)
      else $error("core wrote memory while stopped or halted");

   // halted never survives a cycle with run low.
   halted_needs_run: assert property (@(posedge clk) disable iff (!reset_b)
      halted |-> run && $past(run))
      else $error("halted set without run held high");

endmodule

bind opc_top opc_assert assert_i (
   .clk      (clk),
   .reset_b  (reset_b),
   .bvalid   (bvalid),
   .bready   (bready),
   .run      (run),
   .halted   (halted),
   .core_rnw (cpu_bus.rnw)
);

/* verif/opc_tb.sv */
`timescale 1ns/1ps
`include "opc_macros.svh"

module opc_tb
   import opc_pkg::*;
();

   logic                   clk;
   logic                   reset_b;
   logic [`OPC_AXI_AW-1:0] awaddr;
   logic                   awvalid;
   logic                   awready;
   logic [31:0]            wdata;
   logic [3:0]             wstrb;
   logic                   wvalid;
   logic                   wready;
   axi_resp_t              bresp;
   logic                   bvalid;
   logic                   bready;
   logic [`OPC_AXI_AW-1:0] araddr;
   logic                   arvalid;
   logic                   arready;
   logic [31:0]            rdata;
   axi_resp_t              rresp;
   logic                   rvalid;
   logic                   rready;

   // instruction-set model state.
   data_t m_mem [`OPC_MEM_DEPTH];
   data_t m_acc;
   link_t m_link;
   addr_t m_pc;
   data_t prog [$];

   opc_top dut_i (.*);

   opc_checker chk_i (
      .clk     (clk),
      .awready (awready),
      .wready  (wready),
      .bvalid  (bvalid),
      .bready  (bready),
      .bresp   (bresp),
      .rvalid  (rvalid),
      .rready  (rready),
      .rdata   (rdata),
      .rresp   (rresp)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic axi_write(input logic [13:0] a, input logic [31:0] d, input axi_resp_t r);
      int t;
      chk_i.expect_write(r);
      @(posedge clk);
      awaddr  <= a;
      wdata   <= d;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      t = 0;
      @(posedge clk);
      while (!awready && t < 50)
      begin
         @(posedge clk);
         t++;
      end
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      if (!awready)
         chk_i.note_failure("timeout waiting for awready");
      t = 0;
      @(posedge clk);
      while (!bvalid && t < 50)
      begin
         @(posedge clk);
         t++;
      end
      if (!bvalid)
         chk_i.note_failure("timeout waiting for bvalid");
      // hold the response off for a few cycles.
      repeat ($urandom % 4) @(posedge clk);
      bready <= 1'b1;
      @(posedge clk);
      bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [13:0] a, input logic [31:0] d, input axi_resp_t r,
                           input bit care, output logic [31:0] got);
      int t;
      chk_i.expect_read(d, r, care);
      @(posedge clk);
      araddr  <= a;
      arvalid <= 1'b1;
      t = 0;
      @(posedge clk);
      while (!arready && t < 50)
      begin
         @(posedge clk);
         t++;
      end
      arvalid <= 1'b0;
      if (!arready)
         chk_i.note_failure("timeout waiting for arready");
      t = 0;
      @(posedge clk);
      while (!rvalid && t < 50)
      begin
         @(posedge clk);
         t++;
      end
      if (!rvalid)
         chk_i.note_failure("timeout waiting for rvalid");
      got = rdata;
   endtask

   function automatic bit model_run();
      addr_t   pc;
      addr_t   a;
      addr_t   ea;
      opcode_t op;
      data_t   v;
      link_t   nl;
      bit      done;
      int      n;
      int      sum;
      pc = `OPC_RESET_PC;
      done = 1'b0;
      n = 0;
      while (!done && n < 1000)
      begin
         op = m_mem[pc][7:3];
         a  = {m_mem[pc][2:0], m_mem[pc + 11'd1]};
         // immediate when opcode bit 4 is set.
         v  = op[4] ? a[7:0] : m_mem[a];
         ea = {a[10:8], v};
         m_pc = pc + 11'd2;
         case (op)
            op_sta:  m_mem[a] = m_acc;
            op_stap: m_mem[ea] = m_acc;
            op_ldap: m_acc = m_mem[ea];
            op_jpc:  m_pc = m_link[0] ? a : m_pc;
            op_jpz:  m_pc = (m_acc == 8'd0) ? a : m_pc;
            op_jp:
            begin
               done = (a == pc);
               m_pc = a;
            end
            op_jsr:
            begin
               {m_link, m_acc} = m_pc;
               m_pc = a;
            end
            op_rts:  m_pc = {m_link, m_acc};
            op_lxa:
            begin
               nl = m_acc[2:0];
               m_acc = {5'd0, m_link};
               m_link = nl;
            end
            default:
            begin
               case (op[3:0])
                  4'd0:
                  begin
                     m_acc = m_acc & v;
                     m_link[0] = 1'b0;
                  end
                  4'd1: m_acc = v;
                  4'd2: m_acc = ~v;
                  4'd3:
                  begin
                     // carry in from link, carry out back to link.
                     sum = m_acc + v + m_link[0];
                     m_acc = sum[7:0];
                     m_link[0] = (sum > 255);
                  end
                  default: ;
               endcase
            end
         endcase
         pc = m_pc;
         n++;
      end
      return done;
   endfunction

   task automatic emit(input opcode_t op, input addr_t a);
      prog.push_back({op, a[10:8]});
      prog.push_back(a[7:0]);
   endtask

   task automatic poke(input addr_t a, input data_t d);
      m_mem[a] = d;
      axi_write(14'(a) << 2, {24'd0, d}, okay);
   endtask

   task automatic load_program();
      for (int i = 0; i < prog.size(); i++)
         poke(`OPC_RESET_PC + 11'(i), prog[i]);
   endtask

   task automatic run_and_check();
      logic [31:0] got;
      int          n;
      axi_write(`OPC_CTRL_OFS, 32'd1, okay);
      if (!model_run())
         chk_i.note_failure("model ran past its step limit");
      got = '0;
      n = 0;
      while (!got[0] && n < 200)
      begin
         axi_read(`OPC_STATUS_OFS, 32'd0, okay, 1'b0, got);
         n++;
      end
      if (!got[0])
         chk_i.note_failure("core never reported halted");
      axi_read(`OPC_REGS_OFS, {5'd0, m_pc, 5'd0, m_link, m_acc}, okay, 1'b1, got);
   endtask

   task automatic check_page_zero();
      logic [31:0] got;
      for (int a = 0; a < 256; a++)
         axi_read(14'(a) << 2, {24'd0, m_mem[a]}, okay, 1'b1, got);
   endtask

   task automatic end_test(input string name);
      @(posedge clk);
      chk_i.test_done(name);
   endtask

   initial
   begin
      addr_t       addrs [$];
      addr_t       a;
      logic [31:0] d;
      logic [31:0] got;
      int          n;
      int          sel;
      void'($urandom(25988));
      reset_b = 1'b0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = 4'hf;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b1;
      m_acc   = '0;
      m_link  = '0;
      repeat (16) @(posedge clk);
      reset_b <= 1'b1;
      @(posedge clk);

      for (int i = 0; i < 64; i++)
      begin
         a = 11'($urandom % `OPC_MEM_DEPTH);
         d = $urandom;
         m_mem[a] = d[7:0];
         addrs.push_back(a);
         axi_write(14'(a) << 2, d, okay);
      end
      foreach (addrs[i])
         axi_read(14'(addrs[i]) << 2, {24'd0, m_mem[addrs[i]]}, okay, 1'b1, got);
      end_test("memory window");

      // known page-zero image for the programs.
      for (int i = 0; i < 256; i++)
         poke(11'(i), 8'(i) ^ 8'h5a);
      for (int p = 0; p < 20; p++)
      begin
         prog.delete();
         repeat (4) poke(11'($urandom % 32), 8'($urandom));
         n = 4 + $urandom % 10;
         for (int k = 0; k < n; k++)
         begin
            sel = $urandom % 8;
            if (sel < 4)
               emit({3'b000, 2'(sel)}, 11'($urandom % 32));
            else if (sel < 6)
               emit({3'b100, 2'($urandom % 4)}, 11'($urandom % 256));
            else if (sel == 6)
               emit(op_sta, 11'($urandom % 32));
            else
               emit(op_lxa, 11'd0);
         end
         emit(op_jp, `OPC_RESET_PC + 11'(prog.size()));
         load_program();
         run_and_check();
         axi_write(`OPC_CTRL_OFS, 32'd0, okay);
         check_page_zero();
      end
      end_test("straight-line programs");

      for (int p = 0; p < 5; p++)
      begin
         prog.delete();
         poke(11'h00, ($urandom % 2) ? 8'd0 : 8'($urandom));
         poke(11'h01, 8'($urandom));
         poke(11'h22, 8'($urandom % 32));
         poke(11'h24, 8'($urandom % 32));
         poke(11'h30, 8'd0);
         poke(11'h31, 8'd0);
         // instruction k sits at reset vector plus 2k.
         emit(5'b00001, 11'h00);
         emit(op_jpz, 11'h108);
         emit(5'b10001, 11'haa);
         emit(op_sta, 11'h30);
         emit(5'b00011, 11'h01);
         emit(op_jpc, 11'h110);
         emit(5'b10001, 11'h55);
         emit(op_sta, 11'h31);
         emit(op_jsr, 11'h11c);
         emit(op_sta, 11'h32);
         emit(op_ldap, 11'h22);
         emit(op_sta, 11'h33);
         emit(op_stap, 11'h24);
         emit(op_jp, 11'h11a);
         emit(op_sta, 11'h34);
         emit(op_rts, 11'h000);
         load_program();
         run_and_check();
         axi_write(`OPC_CTRL_OFS, 32'd0, okay);
         check_page_zero();
      end
      end_test("control flow");

      axi_read(14'h3000, 32'd0, slverr, 1'b1, got);
      axi_write(14'h2010, 32'd1, slverr);
      run_and_check();
      axi_write(14'h40 << 2, $urandom, slverr);
      axi_read(14'h40 << 2, 32'd0, slverr, 1'b1, got);
      axi_write(`OPC_CTRL_OFS, 32'd0, okay);
      axi_read(14'h40 << 2, {24'd0, m_mem[11'h40]}, okay, 1'b1, got);
      end_test("error responses");

      axi_read(`OPC_REGS_OFS, {5'd0, `OPC_RESET_PC, 5'd0, m_link, m_acc}, okay, 1'b1, got);
      run_and_check();
      axi_write(`OPC_CTRL_OFS, 32'd0, okay);
      check_page_zero();
      end_test("restart");

      @(posedge clk);
      chk_i.summary();
      if (chk_i.errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

/* flist.f */
+incdir+design
design/opc_pkg.sv
design/opc_bus_if.sv
design/opc_core.sv
design/opc_ram.sv
design/opc_axil_host.sv
design/opc_top.sv
verif/opc_checker.sv
verif/opc_assert.sv
verif/opc_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the simulation with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module opc_tb -f flist.f \
   --Mdir obj_dir -o opc_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/opc_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Finished with errors" sim.log; then
   exit 1
fi
exit 0
